// File: ctl_addr_router.sv
// Master must keep one write and one read outstanding at most; kernel sees truncated addresses
`include "helper_cfg.svh"

module ctl_addr_router (
    input  logic                       ACLK,
    input  logic                       ARESET,

    input  logic                       ctl_awvalid,
    input  helper_axil_pkg::axil_addr_t ctl_awaddr,
    input  logic                       ctl_wvalid,
    input  helper_axil_pkg::axil_data_t ctl_wdata,
    input  helper_axil_pkg::axil_strb_t ctl_wstrb,
    input  logic                       ctl_arvalid,
    input  helper_axil_pkg::axil_addr_t ctl_araddr,
    input  logic                       ctl_rready,
    input  logic                       ctl_bready,
    output logic                       ctl_awready,
    output logic                       ctl_wready,
    output logic                       ctl_arready,
    output logic                       ctl_rvalid,
    output helper_axil_pkg::axil_data_t ctl_rdata,
    output helper_axil_pkg::axil_resp_e ctl_rresp,
    output logic                       ctl_bvalid,
    output helper_axil_pkg::axil_resp_e ctl_bresp,

    output logic                       hlp_awvalid,
    output helper_reg_pkg::helper_addr_t hlp_awaddr,
    output logic                       hlp_wvalid,
    output helper_axil_pkg::axil_data_t hlp_wdata,
    output helper_axil_pkg::axil_strb_t hlp_wstrb,
    output logic                       hlp_arvalid,
    output helper_reg_pkg::helper_addr_t hlp_araddr,
    output logic                       hlp_rready,
    output logic                       hlp_bready,
    input  logic                       hlp_awready,
    input  logic                       hlp_wready,
    input  logic                       hlp_arready,
    input  logic                       hlp_rvalid,
    input  helper_axil_pkg::axil_data_t hlp_rdata,
    input  helper_axil_pkg::axil_resp_e hlp_rresp,
    input  logic                       hlp_bvalid,
    input  helper_axil_pkg::axil_resp_e hlp_bresp,

    output logic                       krn_awvalid,
    output helper_axil_pkg::axil_kaddr_t krn_awaddr,
    output logic                       krn_wvalid,
    output helper_axil_pkg::axil_data_t krn_wdata,
    output helper_axil_pkg::axil_strb_t krn_wstrb,
    output logic                       krn_arvalid,
    output helper_axil_pkg::axil_kaddr_t krn_araddr,
    output logic                       krn_rready,
    output logic                       krn_bready,
    input  logic                       krn_awready,
    input  logic                       krn_wready,
    input  logic                       krn_arready,
    input  logic                       krn_rvalid,
    input  helper_axil_pkg::axil_data_t krn_rdata,
    input  helper_axil_pkg::axil_resp_e krn_rresp,
    input  logic                       krn_bvalid,
    input  helper_axil_pkg::axil_resp_e krn_bresp
);
    import helper_axil_pkg::*;

    logic aw_sel_hlp;
    logic ar_sel_hlp;
    logic aw_hlp_q;
    logic w_sel_hlp;

    // Region decode on the live addresses
    assign aw_sel_hlp = ctl_awaddr[`HELPER_REG_RANGE_BIT];
    assign ar_sel_hlp = ctl_araddr[`HELPER_REG_RANGE_BIT];

    // Write target kept for a W beat that trails its AW
    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            aw_hlp_q <= 1'b0;
        end else if (ctl_awvalid) begin
            aw_hlp_q <= aw_sel_hlp;
        end
    end

    assign w_sel_hlp = (ctl_awvalid & aw_sel_hlp) | aw_hlp_q;

    // Request channels toward the helper
    assign hlp_awvalid = ctl_awvalid & aw_sel_hlp;
    assign hlp_awaddr  = ctl_awaddr[`HELPER_REG_RANGE_BIT-1:0];
    assign hlp_wvalid  = ctl_wvalid & w_sel_hlp;
    assign hlp_wdata   = ctl_wdata;
    assign hlp_wstrb   = ctl_wstrb;
    assign hlp_arvalid = ctl_arvalid & ar_sel_hlp;
    assign hlp_araddr  = ctl_araddr[`HELPER_REG_RANGE_BIT-1:0];
    assign hlp_rready  = ctl_rready;
    assign hlp_bready  = ctl_bready;

    // Request channels toward the kernel, address cut to its width
    assign krn_awvalid = ctl_awvalid & ~aw_sel_hlp;
    assign krn_awaddr  = ctl_awaddr[`HELPER_KERNEL_ADDR_W-1:0];
    assign krn_wvalid  = ctl_wvalid & ~w_sel_hlp;
    assign krn_wdata   = ctl_wdata;
    assign krn_wstrb   = ctl_wstrb;
    assign krn_arvalid = ctl_arvalid & ~ar_sel_hlp;
    assign krn_araddr  = ctl_araddr[`HELPER_KERNEL_ADDR_W-1:0];
    assign krn_rready  = ctl_rready;
    assign krn_bready  = ctl_bready;

    // Ready from the selected side
    assign ctl_awready = aw_sel_hlp ? hlp_awready : krn_awready;
    assign ctl_wready  = w_sel_hlp ? hlp_wready : krn_wready;
    assign ctl_arready = ar_sel_hlp ? hlp_arready : krn_arready;

    // Only one side answers at a time, so responses merge by OR
    assign ctl_rvalid = hlp_rvalid | krn_rvalid;
    assign ctl_rdata  = hlp_rvalid ? hlp_rdata : krn_rdata;
    assign ctl_rresp  = axil_resp_e'(hlp_rresp | krn_rresp);
    assign ctl_bvalid = hlp_bvalid | krn_bvalid;
    assign ctl_bresp  = axil_resp_e'(hlp_bresp | krn_bresp);

    // The OR merge needs read responses from the two slaves never to overlap
    a_rvalid_exclusive: assert property (
        @(posedge ACLK) disable iff (ARESET) !(hlp_rvalid && krn_rvalid)
    );

endmodule

// File: flist.f
+incdir+.
helper_axil_pkg.sv
helper_reg_pkg.sv
ctl_addr_router.sv
helper_reg_file.sv
irq_handshake.sv
kernel_helper.sv
tb_kernel_helper.sv

// File: helper_axil_pkg.sv
// AXI-lite signal types; only OKAY and SLVERR responses are named, other codes pass as raw bits
`include "helper_cfg.svh"

package helper_axil_pkg;

    // Infrastructure side address
    typedef logic [`HELPER_CTL_ADDR_W-1:0] axil_addr_t;

    // Kernel side address, possibly narrower
    typedef logic [`HELPER_KERNEL_ADDR_W-1:0] axil_kaddr_t;

    typedef logic [`HELPER_DATA_W-1:0] axil_data_t;

    typedef logic [`HELPER_DATA_W/8-1:0] axil_strb_t;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axil_resp_e;

endpackage

// File: helper_cfg.svh
// Build-time constants; HELPER_KERNEL_ADDR_W must not exceed HELPER_CTL_ADDR_W, data width is 32
`ifndef HELPER_CFG_SVH
`define HELPER_CFG_SVH

// Address bit that selects the helper region; also the helper offset width
`define HELPER_REG_RANGE_BIT 17

// Infrastructure and kernel AXI-lite address widths
`define HELPER_CTL_ADDR_W 32
`define HELPER_KERNEL_ADDR_W 32

`define HELPER_DATA_W 32

// Context (PASID) width carried with each interrupt
`define HELPER_CTXW 9

// Identification words
`define HELPER_KERNEL_TYPE 32'h0000_ABCD
`define HELPER_RELEASE_LEVEL 32'h0000_0001

// Kernel name, four ASCII words, space padded
`define HELPER_NAME_WORD0 32'h7473_6574
`define HELPER_NAME_WORD1 32'h2020_2020
`define HELPER_NAME_WORD2 32'h2020_2020
`define HELPER_NAME_WORD3 32'h2020_2020

`endif

// File: helper_reg_file.sv
// Responses are always OKAY; IRQ source words are write-only and read back as zero
`include "helper_cfg.svh"

module helper_reg_file (
    input  logic                         ACLK,
    input  logic                         ARESET,
    input  logic                         awvalid,
    input  helper_reg_pkg::helper_addr_t awaddr,
    input  logic                         wvalid,
    input  helper_axil_pkg::axil_data_t  wdata,
    input  helper_axil_pkg::axil_strb_t  wstrb,
    input  logic                         arvalid,
    input  helper_reg_pkg::helper_addr_t araddr,
    input  logic                         rready,
    input  logic                         bready,
    output logic                         awready,
    output logic                         wready,
    output logic                         bvalid,
    output helper_axil_pkg::axil_resp_e  bresp,
    output logic                         arready,
    output logic                         rvalid,
    output helper_axil_pkg::axil_data_t  rdata,
    output helper_axil_pkg::axil_resp_e  rresp,
    output helper_reg_pkg::ctx_t         ctx,
    output helper_reg_pkg::irq_src_t     irq_src
);
    import helper_axil_pkg::*;
    import helper_reg_pkg::*;

    wr_state_e    wr_state;
    wr_state_e    wr_next;
    rd_state_e    rd_state;
    rd_state_e    rd_next;
    helper_addr_t waddr_q;
    logic         aw_hs;
    logic         w_hs;
    logic         ar_hs;
    axil_data_t   src_lo_q;
    axil_data_t   src_hi_q;
    ctx_t         ctx_q;
    axil_data_t   ctx_word;
    axil_data_t   rdata_q;

    // Byte-lane merge of write data into a register
    function automatic axil_data_t strb_merge(
        input axil_data_t cur,
        input axil_data_t din,
        input axil_strb_t strb
    );
        axil_data_t res;
        res = cur;
        for (int i = 0; i < `HELPER_DATA_W/8; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = din[8*i +: 8];
            end
        end
        return res;
    endfunction

    assign aw_hs = awvalid & awready;
    assign w_hs  = wvalid & wready;
    assign ar_hs = arvalid & arready;

    // Write FSM
    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            wr_state <= WR_IDLE;
        end else begin
            wr_state <= wr_next;
        end
    end

    always_comb begin
        wr_next = wr_state;
        case (wr_state)
            WR_IDLE: if (awvalid) wr_next = WR_DATA;
            WR_DATA: if (wvalid) wr_next = WR_RESP;
            WR_RESP: if (bready) wr_next = WR_IDLE;
            default: wr_next = WR_IDLE;
        endcase
    end

    assign awready = (wr_state == WR_IDLE);
    assign wready  = (wr_state == WR_DATA);
    assign bvalid  = (wr_state == WR_RESP);
    assign bresp   = OKAY;

    // Offset captured with AW, used on the W beat
    always_ff @(posedge ACLK) begin
        if (aw_hs) begin
            waddr_q <= awaddr;
        end
    end

    // Writable registers
    assign ctx_word = strb_merge(axil_data_t'(ctx_q), wdata, wstrb);

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            ctx_q    <= '0;
            src_lo_q <= '0;
            src_hi_q <= '0;
        end else if (w_hs) begin
            case (waddr_q)
                CONTEXT:    ctx_q    <= ctx_word[`HELPER_CTXW-1:0];
                IRQ_SRC_LO: src_lo_q <= strb_merge(src_lo_q, wdata, wstrb);
                IRQ_SRC_HI: src_hi_q <= strb_merge(src_hi_q, wdata, wstrb);
                default:    ;
            endcase
        end
    end

    // Read FSM
    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            rd_state <= RD_IDLE;
        end else begin
            rd_state <= rd_next;
        end
    end

    always_comb begin
        rd_next = rd_state;
        case (rd_state)
            RD_IDLE: if (arvalid) rd_next = RD_DATA;
            RD_DATA: if (rready) rd_next = RD_IDLE;
            default: rd_next = RD_IDLE;
        endcase
    end

    assign arready = (rd_state == RD_IDLE);
    assign rvalid  = (rd_state == RD_DATA);
    assign rresp   = OKAY;

    // Read data latched on AR, zero for unmapped offsets
    always_ff @(posedge ACLK) begin
        if (ar_hs) begin
            case (araddr)
                KERNEL_TYPE:   rdata_q <= `HELPER_KERNEL_TYPE;
                RELEASE_LEVEL: rdata_q <= `HELPER_RELEASE_LEVEL;
                CONTEXT:       rdata_q <= axil_data_t'(ctx_q);
                NAME0:         rdata_q <= `HELPER_NAME_WORD0;
                NAME1:         rdata_q <= `HELPER_NAME_WORD1;
                NAME2:         rdata_q <= `HELPER_NAME_WORD2;
                NAME3:         rdata_q <= `HELPER_NAME_WORD3;
                default:       rdata_q <= '0;
            endcase
        end
    end

    assign rdata   = rdata_q;
    assign ctx     = ctx_q;
    assign irq_src = {src_hi_q, src_lo_q};

    // Write response held under back-pressure
    a_bvalid_hold: assert property (
        @(posedge ACLK) disable iff (ARESET)
        (bvalid && !bready) |=> (bvalid && wr_state == WR_RESP)
    );

    // Read data stable while the master stalls
    a_rdata_hold: assert property (
        @(posedge ACLK) disable iff (ARESET)
        (rvalid && !rready) |=> (rvalid && $stable(rdata))
    );

endmodule

// File: helper_reg_pkg.sv
// Helper register map and FSM encodings; offsets are byte addresses inside the helper region
`include "helper_cfg.svh"

package helper_reg_pkg;

    // Offset inside the helper region
    typedef logic [`HELPER_REG_RANGE_BIT-1:0] helper_addr_t;

    // Register offsets, decoded as the register block's opcodes
    typedef enum logic [`HELPER_REG_RANGE_BIT-1:0] {
        KERNEL_TYPE   = 'h10,
        RELEASE_LEVEL = 'h14,
        IRQ_SRC_LO    = 'h18,
        IRQ_SRC_HI    = 'h1C,
        CONTEXT       = 'h20,
        NAME0         = 'h30,
        NAME1         = 'h34,
        NAME2         = 'h38,
        NAME3         = 'h3C
    } reg_offset_e;

    // Write channel FSM
    typedef enum logic [1:0] {
        WR_IDLE = 2'd0,
        WR_DATA = 2'd1,
        WR_RESP = 2'd2
    } wr_state_e;

    // Read channel FSM
    typedef enum logic {
        RD_IDLE = 1'b0,
        RD_DATA = 1'b1
    } rd_state_e;

    typedef logic [`HELPER_CTXW-1:0] ctx_t;

    // Interrupt source address, high word above low word
    typedef logic [63:0] irq_src_t;

endpackage

// File: irq_handshake.sv
// Kernel interrupt is a level; a new edge during a pending request extends it until acknowledged
module irq_handshake (
    input  logic ACLK,
    input  logic ARESET,
    input  logic irq_in,
    input  logic irq_ack,
    output logic irq_req
);

    // Level already seen and turned into a request
    logic edge_q;
    // Request issued, acknowledge not yet received
    logic wait_ack_q;

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            edge_q     <= 1'b0;
            wait_ack_q <= 1'b0;
        end else begin
            wait_ack_q <= (irq_in & ~edge_q) | (wait_ack_q & ~irq_ack);
            // Edge is only consumed once nothing is pending
            edge_q     <= irq_in & (edge_q | ~wait_ack_q);
        end
    end

    // Request in the same cycle as the rising level
    assign irq_req = irq_in & ~edge_q;

    // Without a pending request the pulse is a single cycle
    a_req_single: assert property (
        @(posedge ACLK) disable iff (ARESET)
        (irq_req && !wait_ack_q) |=> !irq_req
    );

endmodule

// File: kernel_helper.sv
// Control-port helper; region bit set selects helper registers, clear passes to the kernel
`include "helper_cfg.svh"

module kernel_helper (
    input  logic                         ACLK,
    input  logic                         ARESET,

    input  logic                         ctl_awvalid,
    input  helper_axil_pkg::axil_addr_t  ctl_awaddr,
    input  logic                         ctl_wvalid,
    input  helper_axil_pkg::axil_data_t  ctl_wdata,
    input  helper_axil_pkg::axil_strb_t  ctl_wstrb,
    input  logic                         ctl_arvalid,
    input  helper_axil_pkg::axil_addr_t  ctl_araddr,
    input  logic                         ctl_rready,
    input  logic                         ctl_bready,
    output logic                         ctl_awready,
    output logic                         ctl_wready,
    output logic                         ctl_arready,
    output logic                         ctl_rvalid,
    output helper_axil_pkg::axil_data_t  ctl_rdata,
    output helper_axil_pkg::axil_resp_e  ctl_rresp,
    output logic                         ctl_bvalid,
    output helper_axil_pkg::axil_resp_e  ctl_bresp,

    output logic                         krn_awvalid,
    output helper_axil_pkg::axil_kaddr_t krn_awaddr,
    output logic                         krn_wvalid,
    output helper_axil_pkg::axil_data_t  krn_wdata,
    output helper_axil_pkg::axil_strb_t  krn_wstrb,
    output logic                         krn_arvalid,
    output helper_axil_pkg::axil_kaddr_t krn_araddr,
    output logic                         krn_rready,
    output logic                         krn_bready,
    input  logic                         krn_awready,
    input  logic                         krn_wready,
    input  logic                         krn_arready,
    input  logic                         krn_rvalid,
    input  helper_axil_pkg::axil_data_t  krn_rdata,
    input  helper_axil_pkg::axil_resp_e  krn_rresp,
    input  logic                         krn_bvalid,
    input  helper_axil_pkg::axil_resp_e  krn_bresp,

    input  logic                         irq_in,
    input  logic                         irq_ack,
    output logic                         irq_req,
    output helper_reg_pkg::irq_src_t     irq_src,
    output helper_reg_pkg::ctx_t         irq_ctx
);
    import helper_axil_pkg::*;
    import helper_reg_pkg::*;

    // Router to helper register file
    logic         hlp_awvalid;
    helper_addr_t hlp_awaddr;
    logic         hlp_wvalid;
    axil_data_t   hlp_wdata;
    axil_strb_t   hlp_wstrb;
    logic         hlp_arvalid;
    helper_addr_t hlp_araddr;
    logic         hlp_rready;
    logic         hlp_bready;
    logic         hlp_awready;
    logic         hlp_wready;
    logic         hlp_arready;
    logic         hlp_rvalid;
    axil_data_t   hlp_rdata;
    axil_resp_e   hlp_rresp;
    logic         hlp_bvalid;
    axil_resp_e   hlp_bresp;

    // All router ports share their names with top ports and wires
    ctl_addr_router u_router (.*);

    helper_reg_file u_regs (
        .ACLK    (ACLK),
        .ARESET  (ARESET),
        .awvalid (hlp_awvalid),
        .awaddr  (hlp_awaddr),
        .wvalid  (hlp_wvalid),
        .wdata   (hlp_wdata),
        .wstrb   (hlp_wstrb),
        .arvalid (hlp_arvalid),
        .araddr  (hlp_araddr),
        .rready  (hlp_rready),
        .bready  (hlp_bready),
        .awready (hlp_awready),
        .wready  (hlp_wready),
        .bvalid  (hlp_bvalid),
        .bresp   (hlp_bresp),
        .arready (hlp_arready),
        .rvalid  (hlp_rvalid),
        .rdata   (hlp_rdata),
        .rresp   (hlp_rresp),
        .ctx     (irq_ctx),
        .irq_src (irq_src)
    );

    irq_handshake u_irq (
        .ACLK    (ACLK),
        .ARESET  (ARESET),
        .irq_in  (irq_in),
        .irq_ack (irq_ack),
        .irq_req (irq_req)
    );

endmodule

// File: run.sh
#!/bin/sh
# Compile with Verilator and run; the log decides the verdict

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f flist.f --top-module tb_kernel_helper \
    --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Testbench failed" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
exit 0

// File: tb_kernel_helper.sv
// Kernel side is a 16-word memory model with one cycle of ready latency; all strobes are full
`include "helper_cfg.svh"

module tb_kernel_helper;
    timeunit 1ns;
    timeprecision 1ps;

    import helper_axil_pkg::*;
    import helper_reg_pkg::*;

    localparam int TIMEOUT_CYCLES = 1000;
    localparam axil_addr_t HLP_BASE = axil_addr_t'(1) << `HELPER_REG_RANGE_BIT;

    logic         ACLK;
    logic         ARESET;
    logic         ctl_awvalid;
    axil_addr_t   ctl_awaddr;
    logic         ctl_wvalid;
    axil_data_t   ctl_wdata;
    axil_strb_t   ctl_wstrb;
    logic         ctl_arvalid;
    axil_addr_t   ctl_araddr;
    logic         ctl_rready;
    logic         ctl_bready;
    logic         ctl_awready;
    logic         ctl_wready;
    logic         ctl_arready;
    logic         ctl_rvalid;
    axil_data_t   ctl_rdata;
    axil_resp_e   ctl_rresp;
    logic         ctl_bvalid;
    axil_resp_e   ctl_bresp;
    logic         krn_awvalid;
    axil_kaddr_t  krn_awaddr;
    logic         krn_wvalid;
    axil_data_t   krn_wdata;
    axil_strb_t   krn_wstrb;
    logic         krn_arvalid;
    axil_kaddr_t  krn_araddr;
    logic         krn_rready;
    logic         krn_bready;
    logic         krn_awready = 1'b0;
    logic         krn_wready = 1'b0;
    logic         krn_arready = 1'b0;
    logic         krn_rvalid = 1'b0;
    axil_data_t   krn_rdata = '0;
    axil_resp_e   krn_rresp = OKAY;
    logic         krn_bvalid = 1'b0;
    axil_resp_e   krn_bresp = OKAY;
    logic         irq_in;
    logic         irq_ack;
    logic         irq_req;
    irq_src_t     irq_src;
    ctx_t         irq_ctx;

    // Kernel memory model state
    axil_data_t   model_mem [16];
    logic         aw_wait = 1'b0;
    logic         w_wait = 1'b0;
    logic         ar_wait = 1'b0;
    logic         aw_have = 1'b0;
    logic         w_have = 1'b0;
    logic         ar_have = 1'b0;
    axil_kaddr_t  model_awaddr = '0;
    axil_kaddr_t  model_araddr = '0;
    axil_data_t   model_wdata = '0;
    axil_strb_t   model_wstrb = '0;

    // Expected state built from the register map
    axil_data_t   ref_mem [16];
    ctx_t         ref_ctx;
    irq_src_t     ref_src;

    logic [31:0]  lcg_state = 32'h5dbe2408;
    string        test_name = "reset";
    axil_addr_t   rd_addr = '0;
    axil_data_t   rd_val;
    axil_data_t   rnd;
    axil_addr_t   kaddr_list [8];
    reg_offset_e  id_offs [6] = '{KERNEL_TYPE, RELEASE_LEVEL, NAME0, NAME1, NAME2, NAME3};

    kernel_helper u_dut (.*);

    always #50 ACLK = ~ACLK;

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic axil_data_t fill_word(input int idx);
        return 32'h6b00_0000 ^ (idx * 32'h0001_0203);
    endfunction

    function automatic axil_addr_t hlp_addr(input helper_addr_t off);
        return HLP_BASE | axil_addr_t'(off);
    endfunction

    // Expected read data for a control address
    function automatic axil_data_t expected_read(input axil_addr_t addr);
        if (!addr[`HELPER_REG_RANGE_BIT]) begin
            return ref_mem[addr[5:2]];
        end
        case (addr[`HELPER_REG_RANGE_BIT-1:0])
            KERNEL_TYPE:   return `HELPER_KERNEL_TYPE;
            RELEASE_LEVEL: return `HELPER_RELEASE_LEVEL;
            CONTEXT:       return axil_data_t'(ref_ctx);
            NAME0:         return `HELPER_NAME_WORD0;
            NAME1:         return `HELPER_NAME_WORD1;
            NAME2:         return `HELPER_NAME_WORD2;
            NAME3:         return `HELPER_NAME_WORD3;
            default:       return '0;
        endcase
    endfunction

    task automatic update_reference(input axil_addr_t addr, input axil_data_t data);
        if (!addr[`HELPER_REG_RANGE_BIT]) begin
            ref_mem[addr[5:2]] = data;
        end else begin
            case (addr[`HELPER_REG_RANGE_BIT-1:0])
                CONTEXT:    ref_ctx = data[`HELPER_CTXW-1:0];
                IRQ_SRC_LO: ref_src[31:0] = data;
                IRQ_SRC_HI: ref_src[63:32] = data;
                default:    ;
            endcase
        end
    endtask

    task automatic stop_on_error();
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout in %s: %s did not arrive within %0d cycles",
                 test_name, what, TIMEOUT_CYCLES);
        stop_on_error();
    endtask

    task automatic check_data(input string name, input axil_data_t exp, input axil_data_t act);
        if (exp !== act) begin
            $display("ERR %s: expected %h, actual %h", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_resp(input string name, input axil_resp_e exp, input axil_resp_e act);
        if (exp !== act) begin
            $display("ERR %s: expected %h, actual %h", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_ctx(input string name, input ctx_t exp, input ctx_t act);
        if (exp !== act) begin
            $display("ERR %s: expected %h, actual %h", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_src(input string name, input irq_src_t exp, input irq_src_t act);
        if (exp !== act) begin
            $display("ERR %s: expected %h, actual %h", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_kaddr(input string name, input axil_kaddr_t exp, input axil_kaddr_t act);
        if (exp !== act) begin
            $display("ERR %s: expected %h, actual %h", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_strb(input string name, input axil_strb_t exp, input axil_strb_t act);
        if (exp !== act) begin
            $display("ERR %s: expected %h, actual %h", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("ERR %s: expected %b, actual %b", name, exp, act);
            stop_on_error();
        end
    endtask

    // Kernel model samples handshakes on the rising edge
    always @(posedge ACLK) begin
        if (ARESET) begin
            aw_wait <= 1'b0;
            w_wait  <= 1'b0;
            ar_wait <= 1'b0;
            aw_have <= 1'b0;
            w_have  <= 1'b0;
            ar_have <= 1'b0;
        end else begin
            aw_wait <= krn_awvalid && !krn_awready;
            w_wait  <= krn_wvalid && !krn_wready;
            ar_wait <= krn_arvalid && !krn_arready;
            if (krn_awvalid && krn_awready) begin
                aw_have      <= 1'b1;
                model_awaddr <= krn_awaddr;
            end
            if (krn_wvalid && krn_wready) begin
                w_have      <= 1'b1;
                model_wdata <= krn_wdata;
                model_wstrb <= krn_wstrb;
            end
            if (krn_bvalid && krn_bready) begin
                aw_have <= 1'b0;
                w_have  <= 1'b0;
            end
            if (krn_arvalid && krn_arready) begin
                ar_have      <= 1'b1;
                model_araddr <= krn_araddr;
            end
            if (krn_rvalid && krn_rready) begin
                ar_have <= 1'b0;
            end
        end
    end

    // Kernel model outputs change on the falling edge
    always @(negedge ACLK) begin
        krn_awready <= aw_wait && !aw_have;
        krn_wready  <= w_wait && !w_have;
        krn_arready <= ar_wait && !ar_have;
        krn_bvalid  <= aw_have && w_have;
        if (aw_have && w_have && !krn_bvalid) begin
            model_mem[model_awaddr[5:2]] <= model_wdata;
        end
        krn_rvalid <= ar_have;
        krn_rdata  <= model_mem[model_araddr[5:2]];
    end

    // Every completed read is compared with the reference
    always @(posedge ACLK) begin
        if (!ARESET && ctl_rvalid && ctl_rready) begin
            check_data({test_name, " rdata"}, expected_read(rd_addr), ctl_rdata);
            check_resp({test_name, " rresp"}, OKAY, ctl_rresp);
        end
    end

    task automatic axil_write(input axil_addr_t addr, input axil_data_t data, input int hold);
        int n;
        @(negedge ACLK);
        ctl_awaddr  = addr;
        ctl_awvalid = 1'b1;
        n = 0;
        @(posedge ACLK);
        while (!ctl_awready) begin
            n++;
            if (n >= TIMEOUT_CYCLES) report_timeout("awready");
            @(posedge ACLK);
        end
        @(negedge ACLK);
        ctl_awvalid = 1'b0;
        ctl_wdata   = data;
        ctl_wstrb   = '1;
        ctl_wvalid  = 1'b1;
        n = 0;
        @(posedge ACLK);
        while (!ctl_wready) begin
            n++;
            if (n >= TIMEOUT_CYCLES) report_timeout("wready");
            @(posedge ACLK);
        end
        @(negedge ACLK);
        ctl_wvalid = 1'b0;
        ctl_bready = (hold == 0);
        n = 0;
        @(posedge ACLK);
        while (!ctl_bvalid) begin
            n++;
            if (n >= TIMEOUT_CYCLES) report_timeout("bvalid");
            @(posedge ACLK);
        end
        if (hold > 0) begin
            repeat (hold) begin
                @(posedge ACLK);
                check_bit({test_name, " bvalid held"}, 1'b1, ctl_bvalid);
            end
            @(negedge ACLK);
            ctl_bready = 1'b1;
            @(posedge ACLK);
        end
        check_resp({test_name, " bresp"}, OKAY, ctl_bresp);
        update_reference(addr, data);
        @(negedge ACLK);
        ctl_bready = 1'b0;
    endtask

    task automatic axil_read(input axil_addr_t addr, input int hold, output axil_data_t data);
        int n;
        axil_data_t first;
        @(negedge ACLK);
        rd_addr     = addr;
        ctl_araddr  = addr;
        ctl_arvalid = 1'b1;
        n = 0;
        @(posedge ACLK);
        while (!ctl_arready) begin
            n++;
            if (n >= TIMEOUT_CYCLES) report_timeout("arready");
            @(posedge ACLK);
        end
        @(negedge ACLK);
        ctl_arvalid = 1'b0;
        ctl_rready  = (hold == 0);
        n = 0;
        @(posedge ACLK);
        while (!ctl_rvalid) begin
            n++;
            if (n >= TIMEOUT_CYCLES) report_timeout("rvalid");
            @(posedge ACLK);
        end
        first = ctl_rdata;
        if (hold > 0) begin
            repeat (hold) begin
                @(posedge ACLK);
                check_bit({test_name, " rvalid held"}, 1'b1, ctl_rvalid);
                check_data({test_name, " rdata held"}, first, ctl_rdata);
            end
            @(negedge ACLK);
            ctl_rready = 1'b1;
            @(posedge ACLK);
        end
        data = first;
        @(negedge ACLK);
        ctl_rready = 1'b0;
    endtask

    task automatic wait_for_irq_req();
        int n;
        n = 0;
        @(posedge ACLK);
        while (!irq_req) begin
            n++;
            if (n >= TIMEOUT_CYCLES) report_timeout("irq_req");
            @(posedge ACLK);
        end
    endtask

    initial begin
        ACLK        = 1'b0;
        ARESET      = 1'b1;
        ctl_awvalid = 1'b0;
        ctl_awaddr  = '0;
        ctl_wvalid  = 1'b0;
        ctl_wdata   = '0;
        ctl_wstrb   = '0;
        ctl_arvalid = 1'b0;
        ctl_araddr  = '0;
        ctl_rready  = 1'b0;
        ctl_bready  = 1'b0;
        irq_in      = 1'b0;
        irq_ack     = 1'b0;
        ref_ctx     = '0;
        ref_src     = '0;
        for (int i = 0; i < 16; i++) begin
            model_mem[i] = fill_word(i);
            ref_mem[i]   = fill_word(i);
        end
        repeat (10) @(posedge ACLK);
        @(negedge ACLK);
        ARESET = 1'b0;

        test_name = "id_read";
        foreach (id_offs[i]) begin
            axil_read(hlp_addr(id_offs[i]), 0, rd_val);
        end

        test_name = "context";
        rnd = next_random();
        axil_write(hlp_addr(CONTEXT), rnd, 0);
        axil_read(hlp_addr(CONTEXT), 0, rd_val);
        check_ctx("context irq_ctx", ref_ctx, irq_ctx);
        // Read-only and unmapped offsets
        axil_write(hlp_addr(KERNEL_TYPE), next_random(), 0);
        axil_write(hlp_addr(NAME0), next_random(), 0);
        axil_read(hlp_addr(KERNEL_TYPE), 0, rd_val);
        axil_read(hlp_addr(NAME0), 0, rd_val);
        axil_read(hlp_addr(17'h40), 0, rd_val);
        axil_read(hlp_addr(IRQ_SRC_LO), 0, rd_val);

        test_name = "kernel_path";
        foreach (kaddr_list[i]) begin
            kaddr_list[i] = next_random() & ~HLP_BASE;
            kaddr_list[i][1:0] = 2'b00;
            axil_write(kaddr_list[i], next_random(), 0);
            check_kaddr({test_name, " kernel awaddr"},
                        kaddr_list[i][`HELPER_KERNEL_ADDR_W-1:0], model_awaddr);
            check_strb({test_name, " kernel wstrb"}, '1, model_wstrb);
        end
        foreach (kaddr_list[i]) begin
            axil_read(kaddr_list[i], 0, rd_val);
            check_kaddr({test_name, " kernel araddr"},
                        kaddr_list[i][`HELPER_KERNEL_ADDR_W-1:0], model_araddr);
        end
        axil_read(hlp_addr(CONTEXT), 0, rd_val);
        check_ctx("kernel_path irq_ctx", ref_ctx, irq_ctx);
        check_src("kernel_path irq_src", ref_src, irq_src);

        test_name = "irq_first";
        axil_write(hlp_addr(IRQ_SRC_LO), next_random(), 0);
        axil_write(hlp_addr(IRQ_SRC_HI), next_random(), 0);
        check_src("irq_first irq_src", ref_src, irq_src);
        @(negedge ACLK);
        irq_in = 1'b1;
        wait_for_irq_req();
        check_src("irq_first req src", ref_src, irq_src);
        check_ctx("irq_first req ctx", ref_ctx, irq_ctx);
        @(posedge ACLK);
        check_bit("irq_first req falls", 1'b0, irq_req);
        repeat (5) begin
            @(posedge ACLK);
            check_bit("irq_first level held", 1'b0, irq_req);
        end

        test_name = "irq_after_ack";
        @(negedge ACLK);
        irq_in  = 1'b0;
        irq_ack = 1'b1;
        @(negedge ACLK);
        irq_ack = 1'b0;
        @(negedge ACLK);
        irq_in = 1'b1;
        wait_for_irq_req();
        @(posedge ACLK);
        check_bit("irq_after_ack req falls", 1'b0, irq_req);
        @(negedge ACLK);
        irq_in  = 1'b0;
        irq_ack = 1'b1;
        @(negedge ACLK);
        irq_ack = 1'b0;

        test_name = "back_pressure";
        axil_write(hlp_addr(CONTEXT), next_random(), 4);
        axil_read(hlp_addr(CONTEXT), 4, rd_val);
        axil_write(kaddr_list[0], next_random(), 4);
        axil_read(kaddr_list[0], 4, rd_val);

        $display("Testbench passed");
        $finish;
    end

endmodule
